// ==== hdl/fetch_cfg.svh ====
`ifndef FETCH_CFG_SVH
`define FETCH_CFG_SVH

// first pc after reset, also the base address of the instruction ROM
`define FETCH_RESET_PC 64'h0000_0000_8000_0000

// ROM depth in 32-bit words
`define FETCH_ROM_WORDS 256

// cycles from request accept to response valid, 1 to 8
`define FETCH_ROM_LATENCY 2

`endif

// ==== hdl/rv_core_pkg.sv ====
`default_nettype none

package rv_core_pkg;

    // program counter
    typedef logic [63:0] pc_t;

    // one 32-bit instruction word
    typedef logic [31:0] inst_t;

    // register file or immediate value
    typedef logic [63:0] xdata_t;

    // where the next pc comes from
    typedef enum logic [2:0] {
        PC_SEQ,   // pc + 4
        PC_JUMP,  // jal or taken branch
        PC_JALR,  // rs1 + imm, bit 0 cleared
        PC_TRAP,  // trap vector
        PC_HOLD   // no change
    } pc_src_e;

endpackage

`default_nettype wire

// ==== hdl/fetch_bus_pkg.sv ====
`default_nettype none

package fetch_bus_pkg;

    // read address on the instruction bus
    typedef logic [63:0] bus_addr_t;

    // byte mask of a transfer, one bit per byte lane
    typedef logic [7:0] bus_size_t;

    // response data, instruction in the low half
    typedef logic [63:0] bus_data_t;

    // fetch read sequencing
    typedef enum logic [1:0] {
        RD_IDLE,  // latch pc for the next request
        RD_REQ,   // request valid, waiting for ready
        RD_WAIT,  // accepted, waiting for response
        RD_ACK    // response ready for one cycle
    } rd_state_e;

endpackage

`default_nettype wire

// ==== hdl/next_pc_sel.sv ====
`default_nettype none

`include "fetch_cfg.svh"

module next_pc_sel (
    input  wire                  clk,
    input  wire                  rst_n_i,
    input  wire                  stall_i,
    input  wire                  ex_jal_i,
    input  wire                  ex_jalr_i,
    input  wire                  ex_branch_i,
    input  wire                  trap_i,
    input  wire rv_core_pkg::pc_t    ex_pc_i,
    input  wire rv_core_pkg::xdata_t ex_imm_i,
    input  wire rv_core_pkg::xdata_t ex_rs1_i,
    input  wire rv_core_pkg::xdata_t ex_alu_res_i,
    input  wire rv_core_pkg::pc_t    mtvec_i,
    input  wire                  fetch_done_i,
    output rv_core_pkg::pc_t     pc_o,
    output logic                 redirect_o
);

    rv_core_pkg::pc_src_e src;
    rv_core_pkg::pc_t     pc_q;
    rv_core_pkg::pc_t     next_pc;
    rv_core_pkg::xdata_t  jalr_sum;

    assign jalr_sum = ex_rs1_i + ex_imm_i;

    // priority: jump/taken branch, jalr, trap, then sequential
    always_comb begin
        if (ex_jal_i || (ex_branch_i && (ex_alu_res_i == '0))) begin
            src = rv_core_pkg::PC_JUMP;
        end else if (ex_jalr_i) begin
            src = rv_core_pkg::PC_JALR;
        end else if (trap_i) begin
            src = rv_core_pkg::PC_TRAP;
        end else if (fetch_done_i && !stall_i) begin
            src = rv_core_pkg::PC_SEQ; // current pc consumed
        end else begin
            src = rv_core_pkg::PC_HOLD;
        end
    end

    always_comb begin
        case (src)
            rv_core_pkg::PC_JUMP: next_pc = ex_pc_i + ex_imm_i;
            rv_core_pkg::PC_JALR: next_pc = {jalr_sum[63:1], 1'b0};
            rv_core_pkg::PC_TRAP: next_pc = mtvec_i;
            rv_core_pkg::PC_SEQ:  next_pc = pc_q + 64'd4;
            default:              next_pc = pc_q;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc_q <= `FETCH_RESET_PC;
        end else begin
            pc_q <= next_pc;
        end
    end

    assign pc_o       = pc_q;
    assign redirect_o = (src == rv_core_pkg::PC_JUMP) || (src == rv_core_pkg::PC_JALR) ||
                        (src == rv_core_pkg::PC_TRAP); // same cycle as the pc change

endmodule

`default_nettype wire

// ==== hdl/inst_fetch.sv ====
`default_nettype none

module inst_fetch (
    input  wire                        clk,
    input  wire                        rst_n_i,
    input  wire rv_core_pkg::pc_t      pc_i,
    input  wire                        redirect_i,
    input  wire                        stall_i,
    input  wire                        req_ready_i,
    input  wire                        rsp_valid_i,
    input  wire fetch_bus_pkg::bus_data_t rsp_data_i,
    output logic                       req_valid_o,
    output fetch_bus_pkg::bus_addr_t   req_addr_o,
    output fetch_bus_pkg::bus_size_t   req_size_o,
    output logic                       rsp_ready_o,
    output logic                       fetch_done_o,
    output rv_core_pkg::inst_t         inst_o,
    output rv_core_pkg::pc_t           inst_pc_o,
    output logic                       inst_valid_o
);

    fetch_bus_pkg::rd_state_e state_q;
    fetch_bus_pkg::bus_addr_t addr_q;   // address of the read in flight
    logic                     stale_q;  // redirect seen since the request was latched
    logic                     rsp_take; // response handshake this cycle
    logic                     keep;     // accepted response belongs to current pc

    // 4-byte instruction read
    assign req_size_o = 8'h0f;

    assign req_valid_o = (state_q == fetch_bus_pkg::RD_REQ);
    assign req_addr_o  = addr_q;
    assign rsp_ready_o = (state_q == fetch_bus_pkg::RD_ACK); // exactly one cycle

    assign rsp_take = rsp_ready_o && rsp_valid_i;

    // a response only counts if nothing moved the pc since the request
    assign keep = rsp_take && (addr_q == pc_i) && !stale_q && !redirect_i;

    // next_pc_sel gates the sequential step with stall itself
    assign fetch_done_o = keep;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= fetch_bus_pkg::RD_IDLE;
            stale_q <= 1'b0;
        end else begin
            case (state_q)
                fetch_bus_pkg::RD_IDLE: begin
                    stale_q <= redirect_i; // pc changes on this edge
                    state_q <= fetch_bus_pkg::RD_REQ;
                end
                fetch_bus_pkg::RD_REQ: begin
                    stale_q <= stale_q || redirect_i;
                    if (req_ready_i) begin
                        state_q <= fetch_bus_pkg::RD_WAIT;
                    end
                end
                fetch_bus_pkg::RD_WAIT: begin
                    stale_q <= stale_q || redirect_i;
                    if (rsp_valid_i) begin
                        state_q <= fetch_bus_pkg::RD_ACK;
                    end
                end
                fetch_bus_pkg::RD_ACK: begin
                    // kept or dropped, the next read starts from the current pc
                    if (rsp_valid_i) begin
                        state_q <= fetch_bus_pkg::RD_IDLE;
                    end
                end
                default: begin
                    state_q <= fetch_bus_pkg::RD_IDLE;
                end
            endcase
        end
    end

    // request address held stable from IDLE until the response is taken
    always_ff @(posedge clk) begin
        if (state_q == fetch_bus_pkg::RD_IDLE) begin
            addr_q <= pc_i;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            inst_valid_o <= 1'b0;
        end else begin
            inst_valid_o <= keep && !stall_i; // stalled response is refetched
        end
    end

    always_ff @(posedge clk) begin
        if (keep) begin
            inst_o    <= rsp_data_i[31:0];
            inst_pc_o <= pc_i;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/inst_rom.sv ====
`default_nettype none

`include "fetch_cfg.svh"

module inst_rom (
    input  wire                        clk,
    input  wire                        rst_n_i,
    input  wire                        req_valid_i,
    input  wire fetch_bus_pkg::bus_addr_t req_addr_i,
    input  wire fetch_bus_pkg::bus_size_t req_size_i,
    input  wire                        rsp_ready_i,
    input  wire                        load_en_i,
    input  wire fetch_bus_pkg::bus_addr_t load_addr_i,
    input  wire rv_core_pkg::inst_t    load_data_i,
    output logic                       req_ready_o,
    output logic                       rsp_valid_o,
    output fetch_bus_pkg::bus_data_t   rsp_data_o
);

    localparam int unsigned IDX_W = $clog2(`FETCH_ROM_WORDS);

    rv_core_pkg::inst_t       mem [`FETCH_ROM_WORDS];
    logic                     busy_q;  // one read pending
    logic [3:0]               cnt_q;   // cycles left until response
    fetch_bus_pkg::bus_data_t data_q;
    fetch_bus_pkg::bus_data_t data_rd;
    logic                     req_take;

    // byte offset from the ROM base, wraps high below the base
    function automatic logic in_rom(input fetch_bus_pkg::bus_addr_t addr);
        fetch_bus_pkg::bus_addr_t off;
        off = addr - `FETCH_RESET_PC;
        return off < 64'(`FETCH_ROM_WORDS * 4);
    endfunction

    function automatic logic [IDX_W-1:0] rom_index(input fetch_bus_pkg::bus_addr_t addr);
        fetch_bus_pkg::bus_addr_t off;
        off = addr - `FETCH_RESET_PC;
        return off[IDX_W+1:2];
    endfunction

    assign req_ready_o = !busy_q;
    assign req_take    = req_valid_i && req_ready_o;
    assign rsp_valid_o = busy_q && (cnt_q == '0); // held until rsp_ready_i
    assign rsp_data_o  = data_q;

    // zero-extended word, then only the lanes asked for
    always_comb begin
        data_rd = '0;
        if (in_rom(req_addr_i)) begin
            data_rd = fetch_bus_pkg::bus_data_t'(mem[rom_index(req_addr_i)]);
        end
        for (int i = 0; i < 8; i++) begin
            if (!req_size_i[i]) begin
                data_rd[8*i +: 8] = 8'h00;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            busy_q <= 1'b0;
            cnt_q  <= '0;
        end else if (req_take) begin
            busy_q <= 1'b1;
            cnt_q  <= 4'(`FETCH_ROM_LATENCY - 1);
        end else if (busy_q && (cnt_q != '0)) begin
            cnt_q <= cnt_q - 4'd1;
        end else if (rsp_valid_o && rsp_ready_i) begin
            busy_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (req_take) begin
            data_q <= data_rd;
        end
    end

    // boot load only while the core is held in reset
    always_ff @(posedge clk) begin
        if (load_en_i && !rst_n_i && in_rom(load_addr_i)) begin
            mem[rom_index(load_addr_i)] <= load_data_i;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/fetch_top.sv ====
`default_nettype none

module fetch_top (
    input  wire                        clk,
    input  wire                        rst_n_i,
    input  wire                        stall_i,
    input  wire                        ex_jal_i,
    input  wire                        ex_jalr_i,
    input  wire                        ex_branch_i,
    input  wire                        trap_i,
    input  wire rv_core_pkg::pc_t      ex_pc_i,
    input  wire rv_core_pkg::xdata_t   ex_imm_i,
    input  wire rv_core_pkg::xdata_t   ex_rs1_i,
    input  wire rv_core_pkg::xdata_t   ex_alu_res_i,
    input  wire rv_core_pkg::pc_t      mtvec_i,
    input  wire                        load_en_i,
    input  wire fetch_bus_pkg::bus_addr_t load_addr_i,
    input  wire rv_core_pkg::inst_t    load_data_i,
    output rv_core_pkg::inst_t         inst_o,
    output rv_core_pkg::pc_t           inst_pc_o,
    output logic                       inst_valid_o
);

    rv_core_pkg::pc_t         pc;
    logic                     redirect;
    logic                     fetch_done;
    logic                     req_valid;
    logic                     req_ready;
    fetch_bus_pkg::bus_addr_t req_addr;
    fetch_bus_pkg::bus_size_t req_size;
    logic                     rsp_valid;
    logic                     rsp_ready;
    fetch_bus_pkg::bus_data_t rsp_data;

    next_pc_sel u_next_pc_sel (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .stall_i      (stall_i),
        .ex_jal_i     (ex_jal_i),
        .ex_jalr_i    (ex_jalr_i),
        .ex_branch_i  (ex_branch_i),
        .trap_i       (trap_i),
        .ex_pc_i      (ex_pc_i),
        .ex_imm_i     (ex_imm_i),
        .ex_rs1_i     (ex_rs1_i),
        .ex_alu_res_i (ex_alu_res_i),
        .mtvec_i      (mtvec_i),
        .fetch_done_i (fetch_done),
        .pc_o         (pc),
        .redirect_o   (redirect)
    );

    inst_fetch u_inst_fetch (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .pc_i         (pc),
        .redirect_i   (redirect),
        .stall_i      (stall_i),
        .req_ready_i  (req_ready),
        .rsp_valid_i  (rsp_valid),
        .rsp_data_i   (rsp_data),
        .req_valid_o  (req_valid),
        .req_addr_o   (req_addr),
        .req_size_o   (req_size),
        .rsp_ready_o  (rsp_ready),
        .fetch_done_o (fetch_done),
        .inst_o       (inst_o),
        .inst_pc_o    (inst_pc_o),
        .inst_valid_o (inst_valid_o)
    );

    inst_rom u_inst_rom (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .req_valid_i  (req_valid),
        .req_addr_i   (req_addr),
        .req_size_i   (req_size),
        .rsp_ready_i  (rsp_ready),
        .load_en_i    (load_en_i),
        .load_addr_i  (load_addr_i),
        .load_data_i  (load_data_i),
        .req_ready_o  (req_ready),
        .rsp_valid_o  (rsp_valid),
        .rsp_data_o   (rsp_data)
    );

endmodule

`default_nettype wire

// ==== sim/fetch_tb.sv ====
`default_nettype none

`include "fetch_cfg.svh"

module fetch_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_NS       = 4;
    localparam int RESET_CYCLES = 8;  // also the boot window, one word per cycle
    localparam int STEP_FIELDS  = 9;

    logic                     clk;
    logic                     rst_n;
    logic                     stall;
    logic                     ex_jal;
    logic                     ex_jalr;
    logic                     ex_branch;
    logic                     trap;
    rv_core_pkg::pc_t         ex_pc;
    rv_core_pkg::xdata_t      ex_imm;
    rv_core_pkg::xdata_t      ex_rs1;
    rv_core_pkg::xdata_t      ex_alu_res;
    rv_core_pkg::pc_t         mtvec;
    logic                     load_en;
    fetch_bus_pkg::bus_addr_t load_addr;
    rv_core_pkg::inst_t       load_data;
    rv_core_pkg::inst_t       inst;
    rv_core_pkg::pc_t         inst_pc;
    logic                     inst_valid;

    logic [63:0]        stim_mem [0:511];
    rv_core_pkg::inst_t prog [0:RESET_CYCLES-1];
    int unsigned        num_prog;
    int unsigned        num_steps;
    int unsigned        wd_cycles = 0;  // set once the stimulus is read
    integer             seed;

    always #(CLK_NS / 2) clk = ~clk;

    fetch_top uut (
        .clk          (clk),
        .rst_n_i      (rst_n),
        .stall_i      (stall),
        .ex_jal_i     (ex_jal),
        .ex_jalr_i    (ex_jalr),
        .ex_branch_i  (ex_branch),
        .trap_i       (trap),
        .ex_pc_i      (ex_pc),
        .ex_imm_i     (ex_imm),
        .ex_rs1_i     (ex_rs1),
        .ex_alu_res_i (ex_alu_res),
        .mtvec_i      (mtvec),
        .load_en_i    (load_en),
        .load_addr_i  (load_addr),
        .load_data_i  (load_data),
        .inst_o       (inst),
        .inst_pc_o    (inst_pc),
        .inst_valid_o (inst_valid)
    );

    task automatic check_value(input string what, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("FAIL @ %0d ns: %s is %h, expected %h", $time, what, got, exp);
            $display("** FAIL **");
            $fatal(1, "mismatch, run stopped");
        end
    endtask

    task automatic stimulus_error(input string msg);
        $display("stimulus file problem: %s", msg);
        $display("** FAIL **");
        $fatal(1, "unusable stimulus file");
    endtask

    // next pc after an action, seq_pc is where sequencing would go
    function automatic rv_core_pkg::pc_t predict_pc(input rv_core_pkg::pc_t seq_pc,
            input logic [7:0] act, input rv_core_pkg::pc_t op_pc,
            input rv_core_pkg::xdata_t op_imm, input rv_core_pkg::xdata_t op_rs1,
            input rv_core_pkg::xdata_t op_alu, input rv_core_pkg::pc_t op_mtvec);
        rv_core_pkg::xdata_t sum;
        sum = op_rs1 + op_imm;
        if (act[0] || (act[1] && (op_alu == 64'd0))) begin
            return op_pc + op_imm;  // jal or taken branch
        end
        if (act[2]) begin
            return sum & ~64'd1;
        end
        if (act[3]) begin
            return op_mtvec;
        end
        return seq_pc;
    endfunction

    // word loaded at pc, unknown outside the boot program
    function automatic rv_core_pkg::inst_t program_word(input rv_core_pkg::pc_t pc);
        rv_core_pkg::pc_t off;
        off = pc - `FETCH_RESET_PC;
        if ((off[1:0] != 2'b00) || ((off >> 2) >= num_prog)) begin
            return 'x;
        end
        return prog[off >> 2];
    endfunction

    task automatic release_pulses();
        ex_jal    <= 1'b0;
        ex_branch <= 1'b0;
        ex_jalr   <= 1'b0;
        trap      <= 1'b0;
    endtask

    task automatic apply_action(input logic [7:0] act, input rv_core_pkg::pc_t op_pc,
            input rv_core_pkg::xdata_t op_imm, input rv_core_pkg::xdata_t op_rs1,
            input rv_core_pkg::xdata_t op_alu, input rv_core_pkg::pc_t op_mtvec,
            input int unsigned n_stall);
        @(posedge clk);
        ex_jal     <= act[0];
        ex_branch  <= act[1];
        ex_jalr    <= act[2];
        trap       <= act[3];
        stall      <= act[4];
        ex_pc      <= op_pc;
        ex_imm     <= op_imm;
        ex_rs1     <= op_rs1;
        ex_alu_res <= op_alu;
        mtvec      <= op_mtvec;
        if (act[4]) begin
            repeat (n_stall) begin
                @(negedge clk);
                check_value("inst_valid_o while stalled", inst_valid, 1'b0);
                @(posedge clk);
                release_pulses();
            end
            stall <= 1'b0;
        end
    endtask

    // returns on the falling edge where inst_valid_o is seen
    task automatic wait_for_emit();
        @(negedge clk);
        while (!inst_valid) begin
            @(posedge clk);
            release_pulses();  // control inputs are one-cycle pulses
            @(negedge clk);
        end
    endtask

    initial begin
        int unsigned        base;
        int unsigned        idx;
        int unsigned        gap;
        int unsigned        stall_total;
        int unsigned        i;
        int unsigned        s;
        logic [7:0]         act;
        rv_core_pkg::pc_t   model_pc;
        rv_core_pkg::pc_t   exp_pc;
        rv_core_pkg::inst_t exp_inst;

        seed       = 23310;
        clk        = 1'b0;
        rst_n      = 1'b0;
        stall      = 1'b0;
        ex_jal     = 1'b0;
        ex_jalr    = 1'b0;
        ex_branch  = 1'b0;
        trap       = 1'b0;
        ex_pc      = '0;
        ex_imm     = '0;
        ex_rs1     = '0;
        ex_alu_res = '0;
        mtvec      = '0;
        load_en    = 1'b0;
        load_addr  = '0;
        load_data  = '0;

        $readmemh("sim/fetch_stimulus.txt", stim_mem);
        if ($isunknown(stim_mem[0]) || (stim_mem[0] == 0) || (stim_mem[0] > RESET_CYCLES)) begin
            stimulus_error("program word count missing or larger than the boot window");
        end
        num_prog = stim_mem[0][31:0];
        for (i = 0; i < num_prog; i++) begin
            prog[i] = stim_mem[1 + i][31:0];
        end
        base = num_prog + 2;
        if ($isunknown(stim_mem[base - 1]) || (stim_mem[base - 1] == 0)) begin
            stimulus_error("step count missing");
        end
        num_steps = stim_mem[base - 1][31:0];
        if ((base + STEP_FIELDS * num_steps > 512) ||
            $isunknown(stim_mem[base + STEP_FIELDS * num_steps - 1])) begin
            stimulus_error("step lines do not match the step count");
        end

        stall_total = 0;
        for (s = 0; s < num_steps; s++) begin
            idx = base + STEP_FIELDS * s;
            if (stim_mem[idx][4]) begin
                stall_total += stim_mem[idx + 6][31:0];
            end
        end
        wd_cycles = num_steps * (`FETCH_ROM_LATENCY + 12) + stall_total + RESET_CYCLES + 2;

        // boot load while the core is held in reset
        for (i = 0; i < RESET_CYCLES; i++) begin
            @(posedge clk);
            load_en   <= (i < num_prog);
            load_addr <= `FETCH_RESET_PC + 64'(4 * i);
            load_data <= (i < num_prog) ? prog[i] : '0;
        end
        @(posedge clk);
        load_en <= 1'b0;
        rst_n   <= 1'b1;

        model_pc = `FETCH_RESET_PC;
        for (s = 0; s < num_steps; s++) begin
            idx = base + STEP_FIELDS * s;
            act = stim_mem[idx][7:0];
            gap = $unsigned($random(seed)) % 4;
            repeat (gap) @(posedge clk);

            exp_pc = predict_pc(model_pc, act, stim_mem[idx + 1], stim_mem[idx + 2],
                                stim_mem[idx + 3], stim_mem[idx + 4], stim_mem[idx + 5]);
            exp_inst = program_word(exp_pc);
            check_value("stimulus expected pc", stim_mem[idx + 7], exp_pc);
            check_value("stimulus expected instruction", stim_mem[idx + 8], exp_inst);

            apply_action(act, stim_mem[idx + 1], stim_mem[idx + 2], stim_mem[idx + 3],
                         stim_mem[idx + 4], stim_mem[idx + 5], stim_mem[idx + 6][31:0]);
            wait_for_emit();
            check_value("inst_pc_o", inst_pc, exp_pc);
            check_value("inst_o", inst, exp_inst);
            model_pc = exp_pc + 64'd4;  // pc already advanced past the emit
        end

        $display("** PASS **");
        $finish;
    end

    initial begin
        wait (wd_cycles != 0);
        #(wd_cycles * CLK_NS);
        $display("timeout: no instruction arrived in time, limit %0d cycles", wd_cycles);
        $display("** FAIL **");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+hdl
hdl/rv_core_pkg.sv
hdl/fetch_bus_pkg.sv
hdl/next_pc_sel.sv
hdl/inst_fetch.sv
hdl/inst_rom.sv
hdl/fetch_top.sv
sim/fetch_tb.sv

// ==== sim/fetch_stimulus.txt ====
// all values hex. program word count, then the words loaded upward from the reset pc,
// then step count, then one step per line with these columns:
// action ex_pc imm rs1 alu_res mtvec stall_cycles expected_pc expected_inst
// action bits: 01 jal, 02 branch, 04 jalr, 08 trap, 10 stall
08
00000093 00100093 00200093 00300093
00400093 00500093 00600093 00700093
16
// sequential fetch after reset
00 00000000 00000000 00000000 00000000 00000000 0 80000000 00000093
00 00000000 00000000 00000000 00000000 00000000 0 80000004 00100093
00 00000000 00000000 00000000 00000000 00000000 0 80000008 00200093
// jal, then taken and not-taken branches
01 80000004 00000010 00000000 00000000 00000000 0 80000014 00500093
00 00000000 00000000 00000000 00000000 00000000 0 80000018 00600093
02 80000008 00000004 00000000 00000000 00000000 0 8000000c 00300093
02 80000000 00000018 00000000 00000005 00000000 0 80000010 00400093
// jalr with odd sum, then jal over jalr
04 00000000 00000004 80000001 00000000 00000000 0 80000004 00100093
05 80000000 0000001c 7fffffe5 00000000 00000000 0 8000001c 00700093
// trap alone, then jal over trap
08 00000000 00000000 00000000 00000000 80000008 0 80000008 00200093
09 80000004 00000008 00000000 00000000 80000018 0 8000000c 00300093
// stalls of different lengths
10 00000000 00000000 00000000 00000000 00000000 6 80000010 00400093
00 00000000 00000000 00000000 00000000 00000000 0 80000014 00500093
10 00000000 00000000 00000000 00000000 00000000 c 80000018 00600093
// jalr over trap, taken branch over trap
0c 00000000 00000000 80000011 00000000 80000000 0 80000010 00400093
0a 80000010 0000000c 00000000 00000000 80000004 0 8000001c 00700093
01 80000000 00000000 00000000 00000000 00000000 0 80000000 00000093
10 00000000 00000000 00000000 00000000 00000000 1 80000004 00100093
// branch not taken lets jalr through
06 80000000 00000000 80000019 00000001 00000000 0 80000018 00600093
10 00000000 00000000 00000000 00000000 00000000 3 8000001c 00700093
08 00000000 00000000 00000000 00000000 80000000 0 80000000 00000093
00 00000000 00000000 00000000 00000000 00000000 0 80000004 00100093
